// File: include/udp_echo_macros.svh
`ifndef UDP_ECHO_MACROS_SVH
`define UDP_ECHO_MACROS_SVH

// UDP destination port answered by the echo logic
`define ECHO_UDP_PORT 16'd1234

// Payload FIFO holds 2**5 = 32 beats
`define PAYLOAD_FIFO_ADDR_W 5

// Board LED count
`define LED_W 8

`endif

// File: src/udp_hdr_pkg.sv
package udp_hdr_pkg;

    // Header field widths
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Header as delivered by the receive side of the UDP stack
    typedef struct packed {
        ip_addr_t  source_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_len_t  length;
    } udp_rx_hdr_t;

    // Reply header handed back to the transmit side
    // Source IP, TTL and checksum are filled in by the stack
    typedef struct packed {
        ip_addr_t  dest_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_len_t  length;
    } udp_reply_hdr_t;

endpackage

// File: src/byte_stream_pkg.sv
package byte_stream_pkg;

    // One payload byte
    typedef logic [7:0] data_byte_t;

    // Payload beat of one byte
    typedef struct packed {
        data_byte_t data;
        logic       last;   // end of datagram
        logic       user;   // error mark from upstream
    } stream_beat_t;

endpackage

// File: src/udp_port_filter.sv
`timescale 1ns/1ps
`include "udp_echo_macros.svh"

module udp_port_filter (
    input  logic                           clk_125mhz,
    input  logic                           rst_125mhz,

    input  udp_hdr_pkg::udp_rx_hdr_t       rx_hdr,
    input  logic                           rx_hdr_valid,
    output logic                           rx_hdr_ready,

    input  byte_stream_pkg::stream_beat_t  rx_payload,
    input  logic                           rx_payload_valid,
    output logic                           rx_payload_ready,

    output udp_hdr_pkg::udp_reply_hdr_t    tx_hdr,
    output logic                           tx_hdr_valid,
    input  logic                           tx_hdr_ready,

    output byte_stream_pkg::stream_beat_t  fifo_in,
    output logic                           fifo_in_valid,
    input  logic                           fifo_in_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_forward,
        st_discard
    } state_t;

    state_t state;
    logic   match;
    logic   hdr_xfer;
    logic   last_xfer;

    // Decision is taken while idle and then held in state
    assign match = (rx_hdr.dest_port == `ECHO_UDP_PORT);

    assign hdr_xfer  = rx_hdr_valid && rx_hdr_ready;
    assign last_xfer = rx_payload_valid && rx_payload_ready && rx_payload.last;

    // Reply goes back to the sender with the ports swapped
    always_comb begin
        tx_hdr.dest_ip     = rx_hdr.source_ip;
        tx_hdr.source_port = rx_hdr.dest_port;
        tx_hdr.dest_port   = rx_hdr.source_port;
        tx_hdr.length      = rx_hdr.length;
    end

    // Header handshake is blocked while a payload is pending
    always_comb begin
        if (state == st_idle) begin
            tx_hdr_valid = rx_hdr_valid && match;
            rx_hdr_ready = match ? tx_hdr_ready : 1'b1;
        end else begin
            tx_hdr_valid = 1'b0;
            rx_hdr_ready = 1'b0;
        end
    end

    // Payload steering
    assign fifo_in = rx_payload;

    always_comb begin
        case (state)
            st_forward: begin
                fifo_in_valid    = rx_payload_valid;
                rx_payload_ready = fifo_in_ready;
            end
            st_discard: begin
                // Sink everything for foreign ports
                fifo_in_valid    = 1'b0;
                rx_payload_ready = 1'b1;
            end
            default: begin
                fifo_in_valid    = 1'b0;
                rx_payload_ready = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (hdr_xfer) begin
                        state <= match ? st_forward : st_discard;
                    end
                end
                st_forward, st_discard: begin
                    if (last_xfer) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: src/payload_fifo.sv
`timescale 1ns/1ps
`include "udp_echo_macros.svh"

module payload_fifo #(
    parameter int ADDR_W = `PAYLOAD_FIFO_ADDR_W
) (
    input  logic                           clk_125mhz,
    input  logic                           rst_125mhz,

    input  byte_stream_pkg::stream_beat_t  in_beat,
    input  logic                           in_valid,
    output logic                           in_ready,

    output byte_stream_pkg::stream_beat_t  out_beat,
    output logic                           out_valid,
    input  logic                           out_ready
);

    localparam int DEPTH = 2 ** ADDR_W;

    byte_stream_pkg::stream_beat_t mem [0:DEPTH-1];

    // Top bit of each pointer is the wrap flag
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic full;
    logic empty;
    logic do_write;
    logic do_read;

    assign empty = (wr_ptr == rd_ptr);

    // Same slot, opposite lap
    assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign in_ready  = !full;
    assign out_valid = !empty;

    // Oldest entry is presented directly from the array
    assign out_beat = mem[rd_ptr[ADDR_W-1:0]];

    assign do_write = in_valid && !full;
    assign do_read  = out_valid && out_ready;

    always_ff @(posedge clk_125mhz) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_W-1:0]] <= in_beat;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: src/first_byte_led.sv
`timescale 1ns/1ps
`include "udp_echo_macros.svh"

module first_byte_led (
    input  logic                           clk_125mhz,
    input  logic                           rst_125mhz,

    input  byte_stream_pkg::stream_beat_t  beat,
    input  logic                           beat_valid,
    input  logic                           beat_ready,

    output logic [`LED_W-1:0]              led
);

    // Set while the rest of a payload is still to come
    logic in_payload;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            in_payload <= 1'b0;
            led        <= '0;
        end else begin
            if (beat_valid && !in_payload) begin
                led <= beat.data;
            end
            // A single-beat payload leaves the flag clear
            if (beat_valid && beat_ready && beat.last) begin
                in_payload <= 1'b0;
            end else if (beat_valid) begin
                in_payload <= 1'b1;
            end
        end
    end

endmodule

// File: src/udp_echo_top.sv
`timescale 1ns/1ps
`include "udp_echo_macros.svh"

module udp_echo_top (
    input  logic                           clk_125mhz,
    input  logic                           rst_125mhz,

    input  udp_hdr_pkg::udp_rx_hdr_t       rx_hdr,
    input  logic                           rx_hdr_valid,
    output logic                           rx_hdr_ready,

    input  byte_stream_pkg::stream_beat_t  rx_payload,
    input  logic                           rx_payload_valid,
    output logic                           rx_payload_ready,

    output udp_hdr_pkg::udp_reply_hdr_t    tx_hdr,
    output logic                           tx_hdr_valid,
    input  logic                           tx_hdr_ready,

    output byte_stream_pkg::stream_beat_t  tx_payload,
    output logic                           tx_payload_valid,
    input  logic                           tx_payload_ready,

    output logic [`LED_W-1:0]              led
);

    // Filter to FIFO
    byte_stream_pkg::stream_beat_t fifo_in;
    logic                          fifo_in_valid;
    logic                          fifo_in_ready;

    udp_port_filter filter_i (
        .clk_125mhz       (clk_125mhz),
        .rst_125mhz       (rst_125mhz),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .fifo_in          (fifo_in),
        .fifo_in_valid    (fifo_in_valid),
        .fifo_in_ready    (fifo_in_ready)
    );

    payload_fifo #(
        .ADDR_W (`PAYLOAD_FIFO_ADDR_W)
    ) fifo_i (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .in_beat    (fifo_in),
        .in_valid   (fifo_in_valid),
        .in_ready   (fifo_in_ready),
        .out_beat   (tx_payload),
        .out_valid  (tx_payload_valid),
        .out_ready  (tx_payload_ready)
    );

    // Watches the outgoing payload only
    first_byte_led led_i (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .beat       (tx_payload),
        .beat_valid (tx_payload_valid),
        .beat_ready (tx_payload_ready),
        .led        (led)
    );

endmodule

// File: verif/udp_echo_props.sv
`timescale 1ns/1ps

module udp_echo_props (
    input logic                          clk_125mhz,
    input logic                          rst_125mhz,
    input logic                          rx_hdr_valid,
    input logic                          rx_hdr_ready,
    input byte_stream_pkg::stream_beat_t rx_payload,
    input logic                          rx_payload_valid,
    input logic                          rx_payload_ready,
    input logic                          tx_hdr_valid,
    input byte_stream_pkg::stream_beat_t tx_payload,
    input logic                          tx_payload_valid,
    input logic                          tx_payload_ready
);

    // Open datagram on the receive side
    logic rx_pending;

    // Number of failed assertions in this run
    int fail_count = 0;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            rx_pending <= 1'b0;
        end else if (rx_hdr_valid && rx_hdr_ready) begin
            rx_pending <= 1'b1;
        end else if (rx_payload_valid && rx_payload_ready && rx_payload.last) begin
            rx_pending <= 1'b0;
        end
    end

    valids_low_after_reset: assert property (
        @(posedge clk_125mhz) rst_125mhz |=> (!tx_hdr_valid && !tx_payload_valid)
    ) else begin
        fail_count++;
        $error("Reply valid high in the cycle after reset");
    end

    tx_payload_held: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        (tx_payload_valid && !tx_payload_ready) |=> (tx_payload_valid && $stable(tx_payload))
    ) else begin
        fail_count++;
        $error("Reply payload changed while stalled");
    end

    no_header_while_pending: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz) rx_pending |-> !rx_hdr_ready
    ) else begin
        fail_count++;
        $error("Header accepted while a payload is pending");
    end

endmodule

bind udp_echo_top udp_echo_props props_i (.*);

// File: verif/udp_echo_tb.sv
`timescale 1ns/1ps
`include "udp_echo_macros.svh"

module udp_echo_tb;

    localparam int NUM_DGRAMS  = 40;
    localparam int MAX_BYTES   = 24;
    localparam int BURST_BYTES = 2 ** `PAYLOAD_FIFO_ADDR_W;
    // 40 datagrams x 26 beats x about 16 for back-pressure and gaps, rounded up
    localparam int MAX_CYCLES  = 20000;

    logic                          clk_125mhz;
    logic                          rst_125mhz;
    udp_hdr_pkg::udp_rx_hdr_t      rx_hdr;
    logic                          rx_hdr_valid;
    logic                          rx_hdr_ready;
    byte_stream_pkg::stream_beat_t rx_payload;
    logic                          rx_payload_valid;
    logic                          rx_payload_ready;
    udp_hdr_pkg::udp_reply_hdr_t   tx_hdr;
    logic                          tx_hdr_valid;
    logic                          tx_hdr_ready;
    byte_stream_pkg::stream_beat_t tx_payload;
    logic                          tx_payload_valid;
    logic                          tx_payload_ready;
    logic [`LED_W-1:0]             led;

    // Expected traffic for datagrams to the echo port only
    udp_hdr_pkg::udp_reply_hdr_t   exp_hdr_q[$];
    byte_stream_pkg::stream_beat_t exp_beat_q[$];
    udp_hdr_pkg::udp_reply_hdr_t   exp_hdr;
    byte_stream_pkg::stream_beat_t exp_beat;
    logic [`LED_W-1:0]             reply_first_byte;
    logic                          reply_start;
    logic                          led_check_due;
    logic                          hold_tx;
    int                            cycle_count;

    udp_echo_top dut_i (.*);

    function automatic udp_hdr_pkg::udp_reply_hdr_t predict_reply(
        input udp_hdr_pkg::udp_rx_hdr_t hdr
    );
        udp_hdr_pkg::udp_reply_hdr_t reply;
        // Back to the sender with the ports swapped
        reply.dest_ip     = hdr.source_ip;
        reply.source_port = hdr.dest_port;
        reply.dest_port   = hdr.source_port;
        reply.length      = hdr.length;
        return reply;
    endfunction

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_hdr(input udp_hdr_pkg::udp_reply_hdr_t got,
                             input udp_hdr_pkg::udp_reply_hdr_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at %0t: reply header %h, expected %h",
                                        $time, got, exp));
        end
    endtask

    task automatic check_beat(input byte_stream_pkg::stream_beat_t got,
                              input byte_stream_pkg::stream_beat_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at %0t: payload beat %h, expected %h",
                                        $time, got, exp));
        end
    endtask

    task automatic check_led(input logic [`LED_W-1:0] got, input logic [`LED_W-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at %0t: led %h, expected %h",
                                        $time, got, exp));
        end
    endtask

    // Each transfer task returns 1 ns after the accepting edge
    task automatic send_header(input udp_hdr_pkg::udp_rx_hdr_t hdr);
        rx_hdr       = hdr;
        rx_hdr_valid = 1'b1;
        @(negedge clk_125mhz);
        while (!rx_hdr_ready) begin
            @(negedge clk_125mhz);
        end
        @(posedge clk_125mhz);
        #1;
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_beat(input byte_stream_pkg::stream_beat_t beat);
        rx_payload       = beat;
        rx_payload_valid = 1'b1;
        @(negedge clk_125mhz);
        while (!rx_payload_ready) begin
            @(negedge clk_125mhz);
        end
        @(posedge clk_125mhz);
        #1;
        rx_payload_valid = 1'b0;
    endtask

    task automatic send_datagram(input bit to_echo, input int nbytes, input bit with_gaps);
        udp_hdr_pkg::udp_rx_hdr_t      hdr;
        byte_stream_pkg::stream_beat_t beat;
        hdr.source_ip   = $urandom();
        hdr.source_port = 16'($urandom_range(65535));
        hdr.dest_port   = `ECHO_UDP_PORT;
        if (!to_echo) begin
            hdr.dest_port = 16'($urandom_range(65535));
            if (hdr.dest_port == `ECHO_UDP_PORT) begin
                hdr.dest_port = hdr.dest_port + 16'd1;
            end
        end
        hdr.length = 16'(nbytes + 8);
        if (to_echo) begin
            exp_hdr_q.push_back(predict_reply(hdr));
        end
        send_header(hdr);
        for (int i = 0; i < nbytes; i++) begin
            beat.data = 8'($urandom_range(255));
            beat.last = (i == nbytes - 1);
            beat.user = ($urandom_range(7) == 0);
            if (to_echo) begin
                exp_beat_q.push_back(beat);
            end
            if (with_gaps && $urandom_range(3) == 0) begin
                @(posedge clk_125mhz);
                #1;
            end
            send_beat(beat);
        end
    endtask

    task automatic wait_drained();
        @(negedge clk_125mhz);
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            @(negedge clk_125mhz);
        end
    endtask

    initial begin
        clk_125mhz = 1'b0;
        forever begin
            #4 clk_125mhz = ~clk_125mhz;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk_125mhz);
            cycle_count++;
        end
        stop_with_failure($sformatf("Timeout: run did not finish within %0d cycles",
                                    MAX_CYCLES));
    end

    // Random back-pressure on both reply channels
    initial begin
        forever begin
            @(posedge clk_125mhz);
            #1;
            tx_hdr_ready     = ($urandom_range(3) != 0);
            tx_payload_ready = !hold_tx && ($urandom_range(9) < 7);
        end
    end

    // Outputs are stable at the falling edge before the transfer edge
    always @(negedge clk_125mhz) begin
        if (rst_125mhz) begin
            reply_start   = 1'b1;
            led_check_due = 1'b0;
        end else begin
            if (led_check_due) begin
                check_led(led, reply_first_byte);
                led_check_due = 1'b0;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    stop_with_failure("Reply header sent for a datagram that should be dropped");
                end else begin
                    exp_hdr = exp_hdr_q.pop_front();
                    check_hdr(tx_hdr, exp_hdr);
                end
            end
            if (tx_payload_valid && tx_payload_ready) begin
                if (exp_beat_q.size() == 0) begin
                    stop_with_failure("Payload beat sent with no echoed datagram outstanding");
                end else begin
                    exp_beat = exp_beat_q.pop_front();
                    check_beat(tx_payload, exp_beat);
                    if (reply_start) begin
                        reply_first_byte = exp_beat.data;
                    end
                    reply_start   = exp_beat.last;
                    led_check_due = exp_beat.last;
                end
            end
        end
    end

    initial begin
        void'($urandom(95));
        rst_125mhz       = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;
        hold_tx          = 1'b0;
        repeat (8) @(posedge clk_125mhz);
        #1;
        rst_125mhz = 1'b0;
        @(negedge clk_125mhz);
        check_led(led, '0);
        @(posedge clk_125mhz);
        #1;
        for (int n = 0; n < NUM_DGRAMS; n++) begin
            send_datagram($urandom_range(1) == 1, $urandom_range(MAX_BYTES, 1), 1'b1);
        end
        // Fill the empty FIFO completely while the reply side is stalled
        wait_drained();
        hold_tx = 1'b1;
        @(posedge clk_125mhz);
        #1;
        send_datagram(1'b1, BURST_BYTES, 1'b0);
        repeat (4) @(negedge clk_125mhz);
        hold_tx = 1'b0;
        wait_drained();
        repeat (2) @(posedge clk_125mhz);
        if (dut_i.props_i.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
src/udp_hdr_pkg.sv
src/byte_stream_pkg.sv
src/udp_port_filter.sv
src/payload_fifo.sv
src/first_byte_led.sv
src/udp_echo_top.sv
verif/udp_echo_props.sv
verif/udp_echo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the UDP echo testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module udp_echo_tb \
    -Mdir "$BUILD_DIR" -o udp_echo_sim \
    -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/udp_echo_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "PASS"
exit 0
